// ==== source/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ram window
`define MEM_RAM_BASE             32'h8000_0000
`define MEM_RAM_WORDS            1024

// uart registers
`define MEM_UART_DATA_ADDR       32'h1000_0000
`define MEM_UART_STATUS_ADDR     32'h1000_0004   // bit 0 = tx_ready

// clint registers, 32-bit only
`define MEM_CLINT_MSIP_ADDR      32'h0200_0000
`define MEM_CLINT_MTIMECMP_ADDR  32'h0200_4000
`define MEM_CLINT_MTIME_ADDR     32'h0200_BFF8

// serial bit time in clk cycles
`define MEM_UART_CLKS_PER_BIT    8

`endif

// ==== source/mmio_pkg.sv ====
package mmio_pkg;

    // where a request lands after decode
    typedef enum logic [2:0] {
        reg_ram,
        reg_uart_data,
        reg_uart_status,
        reg_clint,
        reg_unmapped
    } region_e;

    // clint register select, only meaningful with reg_clint
    typedef enum logic [1:0] {
        clint_msip,
        clint_mtimecmp,
        clint_mtime
    } clint_reg_e;

endpackage

// ==== source/mem_access_pkg.sv ====
package mem_access_pkg;

    import mmio_pkg::*;

    // load codes are funct3; the pipeline also sends a store as its
    // funct3 (0..2) with write set, store members fill the spare codes
    typedef enum logic [2:0] {
        op_lb  = 3'b000,
        op_lh  = 3'b001,
        op_lw  = 3'b010,
        op_sb  = 3'b011,
        op_lbu = 3'b100,
        op_lhu = 3'b101,
        op_sh  = 3'b110,
        op_sw  = 3'b111
    } mem_op_e;

    typedef struct packed {
        mem_op_e     op;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        mem_req_t    req;
        region_e     region;
        logic [1:0]  offset;     // byte within word
        logic [9:0]  word_idx;   // ram word
        clint_reg_e  clint_sel;
    } mem_stage_t;

endpackage

// ==== source/addr_decoder.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module addr_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  mem_access_pkg::mem_req_t   req_i,
    output logic                       stage_valid_o,
    output mem_access_pkg::mem_stage_t stage_o
);

    import mmio_pkg::*;

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
    localparam logic [31:0] RAM_BYTES = 32'(`MEM_RAM_WORDS * 4);

    logic [31:0] ram_off;
    region_e     region;
    clint_reg_e  clint_sel;

    always_comb begin
        ram_off   = req_i.addr - `MEM_RAM_BASE;   // wraps below base, so one compare
        region    = reg_unmapped;
        clint_sel = clint_msip;
        if (ram_off < RAM_BYTES) begin
            region = reg_ram;
        end else begin
            case (req_i.addr)
                `MEM_UART_DATA_ADDR:      region = reg_uart_data;
                `MEM_UART_STATUS_ADDR:    region = reg_uart_status;
                `MEM_CLINT_MSIP_ADDR:     region = reg_clint;
                `MEM_CLINT_MTIMECMP_ADDR: begin
                    region    = reg_clint;
                    clint_sel = clint_mtimecmp;
                end
                `MEM_CLINT_MTIME_ADDR: begin
                    region    = reg_clint;
                    clint_sel = clint_mtime;
                end
                default:                  region = reg_unmapped;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid_o <= 1'b0;
        end else begin
            stage_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        stage_o.req       <= req_i;
        stage_o.region    <= region;
        stage_o.offset    <= req_i.addr[1:0];
        stage_o.word_idx  <= ram_off[IDX_W+1:2];
        stage_o.clint_sel <= clint_sel;
    end

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module data_ram (
    input  logic                       clk,
    input  logic                       stage_valid_i,
    input  mem_access_pkg::mem_stage_t stage_i,
    output logic [31:0]                word_o
);

    import mem_access_pkg::*;
    import mmio_pkg::*;

    logic [31:0] mem [0:`MEM_RAM_WORDS-1];

    logic        do_store;
    logic [3:0]  byte_en;
    logic [31:0] lane_data;

    assign do_store = stage_valid_i && stage_i.req.write && (stage_i.region == reg_ram);

    always_comb begin
        byte_en   = 4'b0000;
        lane_data = stage_i.req.wdata << {stage_i.offset, 3'b000};
        case (stage_i.req.op)
            op_sb, op_lb: byte_en = 4'b0001 << stage_i.offset;
            op_sh, op_lh: begin
                case (stage_i.offset)
                    2'd0:    byte_en = 4'b0011;
                    2'd1:    byte_en = 4'b0110;   // straddles bytes 1 and 2
                    2'd2:    byte_en = 4'b1100;
                    default: byte_en = 4'b0000;   // offset 3 dropped
                endcase
            end
            op_sw, op_lw: begin
                byte_en   = 4'b1111;
                lane_data = stage_i.req.wdata;    // low address bits ignored
            end
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_store) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[stage_i.word_idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    // old contents on a same-cycle store
    always_ff @(posedge clk) begin
        word_o <= mem[stage_i.word_idx];
    end

endmodule

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stage_valid_i,
    input  mem_access_pkg::mem_stage_t stage_i,
    output logic [31:0]                rdata_o,
    output logic                       mtip_o,
    output logic                       msip_o
);

    import mmio_pkg::*;

    logic [31:0] mtime;
    logic [31:0] mtimecmp;
    logic        msip_reg;
    logic        clint_wr;

    assign clint_wr = stage_valid_i && stage_i.req.write && (stage_i.region == reg_clint);

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;    // no timer irq until software arms it
            msip_reg <= 1'b0;
        end else begin
            mtime <= mtime + 32'd1;
            if (clint_wr) begin
                case (stage_i.clint_sel)
                    clint_msip:     msip_reg <= stage_i.req.wdata[0];
                    clint_mtimecmp: mtimecmp <= stage_i.req.wdata;
                    clint_mtime:    mtime    <= stage_i.req.wdata;
                    default:        msip_reg <= msip_reg;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (stage_i.clint_sel)
            clint_msip:     rdata_o <= {31'b0, msip_reg};
            clint_mtimecmp: rdata_o <= mtimecmp;
            clint_mtime:    rdata_o <= mtime;
            default:        rdata_o <= '0;
        endcase
    end

    assign mtip_o = (mtime >= mtimecmp);
    assign msip_o = msip_reg;

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stage_valid_i,
    input  mem_access_pkg::mem_stage_t stage_i,
    output logic                       tx_ready_o,
    output logic                       tx_o
);

    import mmio_pkg::*;

    localparam int CPB    = `MEM_UART_CLKS_PER_BIT;
    localparam int BAUD_W = $clog2(CPB);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    tx_state_e         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        tx_shift;   // byte buffer, shifted out lsb first
    logic              bit_done;
    logic              load_byte;

    assign bit_done  = (baud_cnt == BAUD_W'(CPB - 1));
    // busy writes are lost
    assign load_byte = stage_valid_i && stage_i.req.write
                       && (stage_i.region == reg_uart_data) && (state == tx_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state == tx_idle || bit_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (state)
                tx_idle:  if (load_byte) state <= tx_start;
                tx_start: if (bit_done) state <= tx_data;
                tx_data: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 3'd1;   // wraps back to 0 after bit 7
                        if (bit_cnt == 3'd7) state <= tx_stop;
                    end
                end
                tx_stop:  if (bit_done) state <= tx_idle;
                default:  state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_byte) begin
            tx_shift <= stage_i.req.wdata[7:0];
        end else if (state == tx_data && bit_done) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    always_comb begin
        case (state)
            tx_start: tx_o = 1'b0;
            tx_data:  tx_o = tx_shift[0];
            default:  tx_o = 1'b1;   // idle and stop
        endcase
    end

    assign tx_ready_o = (state == tx_idle);

endmodule

// ==== source/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stage_valid_i,
    input  mem_access_pkg::mem_stage_t stage_i,
    input  logic [31:0]                ram_word_i,
    input  logic [31:0]                clint_word_i,
    input  logic                       tx_ready_i,
    output logic                       rsp_valid_o,
    output logic [31:0]                rsp_rdata_o
);

    import mem_access_pkg::*;
    import mmio_pkg::*;

    logic        stage_valid_q;
    mem_stage_t  stage_q;   // lines up with the registered ram and clint words
    logic [31:0] src_word;
    logic [31:0] shifted;
    logic [31:0] aligned;

    always_comb begin
        case (stage_q.region)
            reg_ram:         src_word = ram_word_i;
            reg_clint:       src_word = clint_word_i;
            reg_uart_status: src_word = {31'b0, tx_ready_i};
            default:         src_word = '0;   // no receiver behind the data reg
        endcase
        shifted = src_word >> {stage_q.offset, 3'b000};
        aligned = '0;
        if (!stage_q.req.write) begin
            case (stage_q.req.op)
                op_lb:  aligned = {{24{shifted[7]}}, shifted[7:0]};
                op_lbu: aligned = {24'b0, shifted[7:0]};
                op_lh:  if (stage_q.offset != 2'd3) aligned = {{16{shifted[15]}}, shifted[15:0]};
                op_lhu: if (stage_q.offset != 2'd3) aligned = {16'b0, shifted[15:0]};
                op_lw:  aligned = src_word;
                default: aligned = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid_q <= 1'b0;
            rsp_valid_o   <= 1'b0;
        end else begin
            stage_valid_q <= stage_valid_i;
            rsp_valid_o   <= stage_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        stage_q     <= stage_i;
        rsp_rdata_o <= aligned;   // stores come back as zero
    end

endmodule

// ==== source/mem_unit_top.sv ====
`timescale 1ns/1ps

module mem_unit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid_i,
    input  mem_access_pkg::mem_req_t req_i,
    output logic                     rsp_valid_o,
    output logic [31:0]              rsp_rdata_o,
    output logic                     mtip_o,
    output logic                     msip_o,
    output logic                     tx_o
);

    import mem_access_pkg::*;

    logic        stage_valid;
    mem_stage_t  stage;
    logic [31:0] ram_word;
    logic [31:0] clint_word;
    logic        tx_ready;

    addr_decoder u_addr_decoder (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .stage_valid_o (stage_valid),
        .stage_o       (stage)
    );

    data_ram u_data_ram (
        .clk           (clk),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .word_o        (ram_word)
    );

    clint_timer u_clint_timer (
        .clk           (clk),
        .rst           (rst),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .rdata_o       (clint_word),
        .mtip_o        (mtip_o),
        .msip_o        (msip_o)
    );

    uart_tx u_uart_tx (
        .clk           (clk),
        .rst           (rst),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .tx_ready_o    (tx_ready),
        .tx_o          (tx_o)
    );

    load_align u_load_align (
        .clk           (clk),
        .rst           (rst),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .ram_word_i    (ram_word),
        .clint_word_i  (clint_word),
        .tx_ready_i    (tx_ready),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o)
    );

endmodule

// ==== verif/tb_mem_unit.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_unit;

    import mem_access_pkg::*;

    localparam int VEC_WORDS  = 6 * 64;   // six columns per input line
    localparam int CPB        = `MEM_UART_CLKS_PER_BIT;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic        check;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] due;    // cycle in which rsp_valid_o must be high
    } exp_t;

    logic        clk;
    logic        rst;
    logic        req_valid_i;
    mem_req_t    req_i;
    logic        rsp_valid_o;
    logic [31:0] rsp_rdata_o;
    logic        mtip_o;
    logic        msip_o;
    logic        tx_o;

    logic [31:0] vec_mem [0:VEC_WORDS-1];
    exp_t        exp_q[$];
    logic [31:0] cap_q[$];   // unchecked responses, kept for polls and mtime
    exp_t        rsp_exp;
    int          cycle_cnt;  // rising edges seen so far

    mem_unit_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .mtip_o      (mtip_o),
        .msip_o      (msip_o),
        .tx_o        (tx_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_fail();
        $display("sim failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic send_req(input logic [2:0] op, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic check,
                            input logic [31:0] exp_data);
        exp_t e;
        @(posedge clk);
        #1;
        req_valid_i = 1'b1;
        req_i.op    = mem_op_e'(op);
        req_i.write = wr;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        e.check     = check;
        e.addr      = addr;
        e.data      = exp_data;
        e.due       = 32'(cycle_cnt + 3);   // sampled next edge, answered two edges later
        exp_q.push_back(e);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic idle_gap();
        int gap;
        gap = int'($urandom % 4);
        if (gap > 0) begin
            go_idle();
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: response to %s never arrived", what);
                stop_fail();
            end
            n++;
            @(posedge clk);
        end
    endtask

    task automatic check_irq(input logic [1:0] exp_irq);
        @(negedge clk);
        assert ({msip_o, mtip_o} == exp_irq)
            else begin
                $display("error %0t: {msip,mtip} is %b, expected %b",
                         $time, {msip_o, mtip_o}, exp_irq);
                stop_fail();
            end
    endtask

    // two mtime loads sampled k edges apart
    task automatic check_mtime(input int k);
        logic [31:0] t0;
        logic [31:0] t1;
        go_idle();
        wait_drain("earlier request");
        cap_q.delete();
        send_req(3'd2, 1'b0, `MEM_CLINT_MTIME_ADDR, '0, 1'b0, '0);
        if (k > 1) begin
            go_idle();
            repeat (k - 2) @(posedge clk);
        end
        send_req(3'd2, 1'b0, `MEM_CLINT_MTIME_ADDR, '0, 1'b0, '0);
        go_idle();
        wait_drain("mtime load");
        if (cap_q.size() != 2) begin
            $display("mtime test got %0d responses instead of two", cap_q.size());
            stop_fail();
        end
        t0 = cap_q[0];
        t1 = cap_q[1];
        assert ((t1 - t0) == 32'(k))
            else begin
                $display("error %0t: mtime moved by %0d, expected %0d", $time, t1 - t0, k);
                stop_fail();
            end
    endtask

    task automatic poll_ready();
        int          n;
        logic [31:0] status;
        n      = 0;
        status = '0;
        while (status[0] !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: uart tx_ready never came up");
                stop_fail();
            end
            n++;
            cap_q.delete();
            send_req(3'd2, 1'b0, `MEM_UART_STATUS_ADDR, '0, 1'b0, '0);
            go_idle();
            wait_drain("uart status read");
            status = cap_q.pop_front();
        end
    endtask

    task automatic check_tx_bit(input logic exp_bit, input int bit_no);
        assert (tx_o === exp_bit)
            else begin
                $display("error %0t: tx bit %0d is %b, expected %b", $time, bit_no, tx_o, exp_bit);
                stop_fail();
            end
    endtask

    task automatic check_uart(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [7:0] exp_byte);
        int n;
        go_idle();
        wait_drain("earlier request");
        poll_ready();
        send_req(3'd0, 1'b1, addr, wdata, 1'b1, '0);
        send_req(3'd2, 1'b0, `MEM_UART_STATUS_ADDR, '0, 1'b1, '0);   // busy once the byte is in
        go_idle();
        n = 0;
        @(negedge clk);
        while (tx_o !== 1'b0) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: uart start bit never appeared on tx");
                stop_fail();
            end
            n++;
            @(negedge clk);
        end
        repeat (CPB / 2 - 1) @(negedge clk);   // middle of start bit
        check_tx_bit(1'b0, 0);
        for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            check_tx_bit(exp_byte[i], i + 1);
        end
        repeat (CPB) @(negedge clk);
        check_tx_bit(1'b1, 9);   // stop
        wait_drain("uart write");
    endtask

    // scoreboard, responses are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("a response came back with no request outstanding");
                stop_fail();
            end else begin
                rsp_exp = exp_q.pop_front();
                assert (32'(cycle_cnt) == rsp_exp.due)
                    else begin
                        $display("error %0t: addr %h answered in cycle %0d, expected cycle %0d",
                                 $time, rsp_exp.addr, cycle_cnt, rsp_exp.due);
                        stop_fail();
                    end
                if (rsp_exp.check) begin
                    assert (rsp_rdata_o == rsp_exp.data)
                        else begin
                            $display("error %0t: addr %h read %h, expected %h",
                                     $time, rsp_exp.addr, rsp_rdata_o, rsp_exp.data);
                            stop_fail();
                        end
                end else begin
                    cap_q.push_back(rsp_rdata_o);
                end
            end
        end
    end

    initial begin
        int          base;
        logic [31:0] kind;
        logic [2:0]  op;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        logic        seen_end;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        seen_end    = 1'b0;
        void'($urandom(32'h7df9));
        $readmemh("verif/mem_input.txt", vec_mem);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!rsp_valid_o && tx_o && !msip_o && !mtip_o)
            else begin
                $display("error %0t: outputs after reset are valid %b tx %b msip %b mtip %b",
                         $time, rsp_valid_o, tx_o, msip_o, mtip_o);
                stop_fail();
            end
        for (int i = 0; i < VEC_WORDS / 6; i++) begin
            base    = 6 * i;
            kind    = vec_mem[base];
            op      = vec_mem[base + 1][2:0];
            wr      = vec_mem[base + 2][0];
            addr    = vec_mem[base + 3];
            wdata   = vec_mem[base + 4];
            exp_val = vec_mem[base + 5];
            if (kind == 32'hf) begin
                seen_end = 1'b1;
                break;
            end
            case (kind)
                32'h0: begin
                    send_req(op, wr, addr, wdata, 1'b1, exp_val);
                    idle_gap();
                end
                32'h1: check_uart(addr, wdata, exp_val[7:0]);
                32'h2: begin
                    go_idle();
                    wait_drain("earlier request");
                    send_req(op, wr, addr, wdata, 1'b1, '0);
                    go_idle();
                    wait_drain("clint access");
                    check_irq(exp_val[1:0]);
                end
                32'h3: check_mtime(int'(wdata));
                default: begin
                    $display("input file has an unknown line kind %h", kind);
                    stop_fail();
                end
            endcase
        end
        if (!seen_end) begin
            $display("input file has no end line");
            stop_fail();
        end
        go_idle();
        wait_drain("last request");
        $display("sim passed");
        $finish;
    end

endmodule

// ==== verif/mem_input.txt ====
// kind op write addr wdata expected (hex)
// kind 0 request, 1 uart byte, 2 irq lines {msip,mtip}, 3 mtime pair k=wdata, f end
0 2 1 80000000 11223344 00000000
0 2 1 80000004 a5a5f00d 00000000
0 2 1 80000ffc cafebabe 00000000
0 2 0 80000000 00000000 11223344
0 2 0 80000004 00000000 a5a5f00d
0 2 0 80000ffc 00000000 cafebabe
// byte and half lanes
0 2 1 80000010 00000000 00000000
0 0 1 80000010 00000081 00000000
0 0 1 80000013 0000007f 00000000
0 1 1 80000011 0000beef 00000000
0 2 0 80000010 00000000 7fbeef81
0 0 0 80000010 00000000 ffffff81
0 4 0 80000010 00000000 00000081
0 0 0 80000013 00000000 0000007f
0 1 0 80000011 00000000 ffffbeef
0 5 0 80000011 00000000 0000beef
0 1 0 80000012 00000000 00007fbe
0 4 0 80000012 00000000 000000be
0 1 1 80000020 00001234 00000000
0 1 1 80000022 00008001 00000000
0 0 1 80000021 00000055 00000000
0 2 0 80000020 00000000 80015534
0 1 0 80000022 00000000 ffff8001
0 5 0 80000020 00000000 00005534
// unmapped and halfword at offset 3
0 2 0 40000000 00000000 00000000
0 2 1 40000000 deadbeef 00000000
0 2 0 40000000 00000000 00000000
0 1 1 80000013 0000ffff 00000000
0 2 1 80001000 12345678 00000000
0 2 0 80000010 00000000 7fbeef81
0 2 0 80000000 00000000 11223344
// clint
2 2 1 02004000 ffffffff 00000000
2 2 1 02004000 00000000 00000001
2 2 1 02000000 00000001 00000003
0 2 0 02000000 00000000 00000001
0 2 0 02004000 00000000 00000000
2 2 1 02004000 ffffffff 00000002
2 2 1 02000000 00000000 00000000
3 2 0 0200bff8 00000005 00000000
3 2 0 0200bff8 00000001 00000000
// uart
1 0 1 10000000 000000a5 000000a5
1 0 1 10000000 0000003c 0000003c
f 0 0 00000000 00000000 00000000

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_mem_unit -o sim_mem_unit \
    && ./obj_dir/sim_mem_unit 2>&1 | tee sim.log

grep -q "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== flist.f ====
+incdir+source
source/mmio_pkg.sv
source/mem_access_pkg.sv
source/addr_decoder.sv
source/data_ram.sv
source/clint_timer.sv
source/uart_tx.sv
source/load_align.sv
source/mem_unit_top.sv
verif/tb_mem_unit.sv
